/* design/qspi_cfg_pkg.sv */
//--------------------------------------------------------------------
// Serial flash controller configuration
// Fixed timing and sizing constants shared by every stage
//--------------------------------------------------------------------
`default_nettype none

package qspi_cfg_pkg;

  // Host word width, command and response
  localparam int WORD_W    = 32;
  // sck half period in clk cycles
  localparam int SCK_HALF  = 2;
  // Chip select framing around the serial clock
  localparam int CS_SETUP  = 2;
  localparam int CS_HOLD   = 2;
  // Quiet cycles between two transactions
  localparam int CMD_GAP   = 2;
  // Command queue depth, also the host's starting credits
  localparam int CMD_DEPTH = 4;
  localparam int BIT_CNT_W = 8;
  localparam int CS_NUM    = 2;

endpackage

`default_nettype wire

/* design/qspi_cmd_pkg.sv */
//--------------------------------------------------------------------
// Serial flash command format
// Header word layout, phase sequence codes and shift directions
//--------------------------------------------------------------------
`default_nettype none

package qspi_cmd_pkg;

  // Phase sequences, C command, A address, D dummy, R read, W write
  typedef enum logic [3:0] {
    SEQ_C    = 4'b0000,
    SEQ_CW   = 4'b0001,
    SEQ_CA   = 4'b0010,
    SEQ_CAR  = 4'b0011,
    SEQ_CADR = 4'b0100,
    SEQ_CAW  = 4'b0111,
    SEQ_CDR  = 4'b1010,
    SEQ_CR   = 4'b1100
  } qspi_seq_t;

  // Header word, first word of every command
  // Byte counts of address and data hold the count minus one
  typedef struct packed {
    logic [10:0] rsvd;
    logic        cs_sel;
    logic [1:0]  data_bytes;
    logic [3:0]  dummy_bytes;
    logic [1:0]  addr_bytes;
    qspi_seq_t   seq;
    logic [7:0]  opcode;
  } qspi_hdr_t;

  // Direction of one shift request
  typedef enum logic [1:0] {
    SH_TX    = 2'b00,
    SH_DUMMY = 2'b01,
    SH_RX    = 2'b10
  } qspi_dir_t;

endpackage

`default_nettype wire

/* design/qspi_link_if.sv */
//--------------------------------------------------------------------
// Internal links of the flash controller
// Shift requests from sequencer to shifter, sck control to the
// clock generator
//--------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

interface qspi_shift_if import qspi_cfg_pkg::*, qspi_cmd_pkg::*; ();
  logic                 req_valid;
  qspi_dir_t            req_dir;
  logic [BIT_CNT_W-1:0] req_bits;
  // Left aligned, first bit in the MSB
  logic [WORD_W-1:0]    req_data;
  logic                 req_ready;
  logic                 done;
  logic [WORD_W-1:0]    rx_word;

  modport seq   (output req_valid, req_dir, req_bits, req_data,
                 input  req_ready, done, rx_word);
  modport shift (input  req_valid, req_dir, req_bits, req_data,
                 output req_ready, done, rx_word);
endinterface

interface qspi_sck_if;
  logic run;
  logic shift_edge;
  logic sample_edge;
  logic idle;

  modport gen  (input run, output shift_edge, sample_edge, idle);
  modport user (output run, input shift_edge, sample_edge, idle);
endinterface

`default_nettype wire

/* design/qspi_cmd_buffer.sv */
//--------------------------------------------------------------------
// Command word queue
// Holds host command words and returns one credit per word popped
//--------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module qspi_cmd_buffer import qspi_cfg_pkg::*; (
  input  logic              clk,
  input  logic              rstn,
  input  logic              cmd_valid,
  input  logic [WORD_W-1:0] cmd_word,
  output logic              cmd_credit,
  output logic              word_valid,
  output logic [WORD_W-1:0] word,
  input  logic              word_pop
);

  logic [WORD_W-1:0]          mem [CMD_DEPTH];
  // Extra MSB tells full from empty
  logic [$clog2(CMD_DEPTH):0] wr_ptr;
  logic [$clog2(CMD_DEPTH):0] rd_ptr;

  // Host never pushes without a credit, so no full check
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      cmd_credit <= 1'b0;
    end else begin
      if (cmd_valid)
        wr_ptr <= wr_ptr + 1'b1;
      if (word_pop)
        rd_ptr <= rd_ptr + 1'b1;
      // Credit goes back one cycle after the pop
      cmd_credit <= word_pop;
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_valid)
      mem[wr_ptr[$clog2(CMD_DEPTH)-1:0]] <= cmd_word;
  end

  // Head of queue
  assign word_valid = (wr_ptr != rd_ptr);
  assign word       = mem[rd_ptr[$clog2(CMD_DEPTH)-1:0]];

endmodule

`default_nettype wire

/* design/qspi_sequencer.sv */
//--------------------------------------------------------------------
// Transaction sequencer
// Walks one command through its phases, drives the chip selects
// and returns read words under response credit
//--------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module qspi_sequencer import qspi_cfg_pkg::*, qspi_cmd_pkg::*; (
  input  logic              clk,
  input  logic              rstn,
  input  logic              word_valid,
  input  logic [WORD_W-1:0] word,
  output logic              word_pop,
  input  logic              rsp_credit,
  output logic              rsp_valid,
  output logic [WORD_W-1:0] rsp_word,
  output logic [CS_NUM-1:0] csn,
  qspi_shift_if.seq         shift
);

  typedef enum logic [3:0] {
    S_IDLE, S_SETUP, S_CMD, S_ADDR, S_DUMMY,
    S_WRITE, S_READ, S_DONE, S_HOLD, S_GAP
  } state_t;

  state_t               state;
  state_t               state_nxt;
  state_t               pre_read;
  qspi_hdr_t            hdr;
  qspi_hdr_t            hdr_in;
  logic [3:0]           tmr;
  logic [7:0]           rsp_cred;
  logic                 seq_rd;
  logic                 take;
  logic                 rsp_take;
  logic [BIT_CNT_W-1:0] data_bits;
  logic [WORD_W-1:0]    wr_swap;

  assign hdr_in    = qspi_hdr_t'(word);
  assign take      = shift.req_valid & shift.req_ready;
  assign seq_rd    = hdr.seq inside {SEQ_CAR, SEQ_CADR, SEQ_CDR, SEQ_CR};
  assign pre_read  = (hdr.dummy_bytes != 4'd0) ? S_DUMMY : S_READ;
  assign data_bits = BIT_CNT_W'({{1'b0, hdr.data_bytes} + 3'd1, 3'b000});
  // Little endian, byte 0 leaves first
  assign wr_swap   = {word[7:0], word[15:8], word[23:16], word[31:24]};
  // Read word returns once the last bit is in
  assign rsp_take  = (state == S_DONE) & shift.done & seq_rd;

  //------------------------------------------------------------------
  // Phase FSM
  //------------------------------------------------------------------
  always_comb begin
    state_nxt       = state;
    word_pop        = 1'b0;
    shift.req_valid = 1'b0;
    shift.req_dir   = SH_TX;
    shift.req_bits  = '0;
    shift.req_data  = '0;
    case (state)
      S_IDLE: begin
        // Header word consumed here
        if (word_valid) begin
          word_pop  = 1'b1;
          state_nxt = S_SETUP;
        end
      end
      S_SETUP: if (tmr == 4'(CS_SETUP - 1)) state_nxt = S_CMD;
      S_CMD: begin
        shift.req_valid = 1'b1;
        shift.req_bits  = BIT_CNT_W'(8);
        shift.req_data  = {hdr.opcode, {(WORD_W - 8){1'b0}}};
        if (take) begin
          case (hdr.seq)
            SEQ_CW:  state_nxt = S_WRITE;
            SEQ_CA, SEQ_CAR, SEQ_CADR, SEQ_CAW: state_nxt = S_ADDR;
            SEQ_CDR: state_nxt = pre_read;
            SEQ_CR:  state_nxt = S_READ;
            default: state_nxt = S_DONE;
          endcase
        end
      end
      S_ADDR: begin
        // Low address bytes moved up to the MSB end
        shift.req_valid = word_valid;
        shift.req_bits  = BIT_CNT_W'({{1'b0, hdr.addr_bytes} + 3'd1, 3'b000});
        shift.req_data  = word << {~hdr.addr_bytes, 3'b000};
        if (take) begin
          word_pop = 1'b1;
          case (hdr.seq)
            SEQ_CAR:  state_nxt = S_READ;
            SEQ_CADR: state_nxt = pre_read;
            SEQ_CAW:  state_nxt = S_WRITE;
            default:  state_nxt = S_DONE;
          endcase
        end
      end
      S_DUMMY: begin
        shift.req_valid = 1'b1;
        shift.req_dir   = SH_DUMMY;
        shift.req_bits  = BIT_CNT_W'({hdr.dummy_bytes, 3'b000});
        if (take) state_nxt = S_READ;
      end
      S_WRITE: begin
        shift.req_valid = word_valid;
        shift.req_bits  = data_bits;
        shift.req_data  = wr_swap;
        if (take) begin
          word_pop  = 1'b1;
          state_nxt = S_DONE;
        end
      end
      S_READ: begin
        // Back-pressure, no read until the host grants a slot
        shift.req_valid = (rsp_cred != 8'd0);
        shift.req_dir   = SH_RX;
        shift.req_bits  = data_bits;
        if (take) state_nxt = S_DONE;
      end
      S_DONE:  if (shift.done) state_nxt = S_HOLD;
      S_HOLD:  if (tmr == 4'(CS_HOLD - 1)) state_nxt = S_GAP;
      S_GAP:   if (tmr == 4'(CMD_GAP - 1)) state_nxt = S_IDLE;
      default: state_nxt = S_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state     <= S_IDLE;
      tmr       <= '0;
      hdr       <= '0;
      csn       <= '1;
      rsp_valid <= 1'b0;
      rsp_cred  <= '0;
    end else begin
      state     <= state_nxt;
      // Phase timer restarts on every state change
      tmr       <= (state_nxt != state) ? 4'd0 : tmr + 1'b1;
      rsp_valid <= rsp_take;
      if (state == S_IDLE && word_valid) begin
        hdr <= hdr_in;
        csn <= ~(CS_NUM'(1) << hdr_in.cs_sel);
      end
      if (state == S_HOLD && state_nxt == S_GAP)
        csn <= '1;
      // Response credit count
      case ({rsp_credit, rsp_take})
        2'b10:   rsp_cred <= rsp_cred + 1'b1;
        2'b01:   rsp_cred <= rsp_cred - 1'b1;
        default: rsp_cred <= rsp_cred;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rsp_take)
      rsp_word <= shift.rx_word;
  end

endmodule

`default_nettype wire

/* design/qspi_sck_gen.sv */
//--------------------------------------------------------------------
// SCK generator
// Divides clk down to a mode 0 serial clock and flags its edges
//--------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module qspi_sck_gen import qspi_cfg_pkg::*; (
  input  logic   clk,
  input  logic   rstn,
  output logic   sck,
  qspi_sck_if.gen sck_bus
);

  logic [$clog2(SCK_HALF)-1:0] half_cnt;
  logic                        shift_q;
  logic                        sample_q;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      half_cnt <= '0;
      sck      <= 1'b0;
      shift_q  <= 1'b0;
      sample_q <= 1'b0;
    end else begin
      shift_q  <= 1'b0;
      sample_q <= 1'b0;
      // Stops only in the low phase, a high phase always finishes
      if (!sck_bus.run && !sck) begin
        half_cnt <= '0;
      end else if (half_cnt == $clog2(SCK_HALF)'(SCK_HALF - 1)) begin
        half_cnt <= '0;
        sck      <= ~sck;
        sample_q <= ~sck;
        shift_q  <= sck;
      end else begin
        half_cnt <= half_cnt + 1'b1;
      end
    end
  end

  // Edge flags line up with the new sck level
  assign sck_bus.shift_edge  = shift_q;
  assign sck_bus.sample_edge = sample_q;
  assign sck_bus.idle        = ~sck & ~sck_bus.run;

endmodule

`default_nettype wire

/* design/qspi_shifter.sv */
//--------------------------------------------------------------------
// Bit shifter
// Serializes transmit phases MSB first and assembles read bytes
// into their little endian lanes
//--------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module qspi_shifter import qspi_cfg_pkg::*, qspi_cmd_pkg::*; (
  input  logic        clk,
  input  logic        rstn,
  qspi_shift_if.shift shift,
  qspi_sck_if.user    sck_bus,
  output logic        mosi,
  output logic        mosi_en,
  input  logic        miso
);

  logic                 busy;
  qspi_dir_t            dir;
  logic [BIT_CNT_W-1:0] bit_cnt;
  logic [WORD_W-1:0]    tx_sr;
  logic [7:0]           rx_byte;
  logic [7:0]           rx_byte_nxt;
  logic [1:0]           rx_idx;
  logic [WORD_W-1:0]    rx_word_q;
  logic                 done_q;
  logic                 take;

  assign take              = shift.req_valid & shift.req_ready;
  assign shift.req_ready   = ~busy;
  assign shift.done        = done_q;
  assign shift.rx_word     = rx_word_q;
  // sck runs while bits remain
  assign sck_bus.run       = busy & (bit_cnt != '0);
  assign rx_byte_nxt       = {rx_byte[6:0], miso};
  // Dummy and read phases leave mosi undriven
  assign mosi_en           = busy & (dir == SH_TX);
  assign mosi              = mosi_en & tx_sr[WORD_W-1];

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      busy    <= 1'b0;
      dir     <= SH_TX;
      bit_cnt <= '0;
      rx_idx  <= '0;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (take) begin
        busy    <= 1'b1;
        dir     <= shift.req_dir;
        bit_cnt <= shift.req_bits;
        rx_idx  <= '0;
      end else if (busy) begin
        // One bit per rising edge
        if (sck_bus.sample_edge && bit_cnt != '0) begin
          bit_cnt <= bit_cnt - 1'b1;
          if (dir == SH_RX && bit_cnt[2:0] == 3'd1)
            rx_idx <= rx_idx + 1'b1;
        end
        // Finished once the count is out and sck is back low
        if (bit_cnt == '0 && sck_bus.idle) begin
          busy   <= 1'b0;
          done_q <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      tx_sr     <= shift.req_data;
      rx_word_q <= '0;
    end else if (busy) begin
      // Next bit goes out on the falling edge
      if (sck_bus.shift_edge && bit_cnt != '0)
        tx_sr <= {tx_sr[WORD_W-2:0], 1'b0};
      if (sck_bus.sample_edge && dir == SH_RX) begin
        rx_byte <= rx_byte_nxt;
        // Full byte lands in the lane of its arrival order
        if (bit_cnt[2:0] == 3'd1)
          rx_word_q[{rx_idx, 3'b000} +: 8] <= rx_byte_nxt;
      end
    end
  end

endmodule

`default_nettype wire

/* design/qspi_top.sv */
//--------------------------------------------------------------------
// Serial flash controller top level
// Command queue, phase sequencer, shifter and sck generator
//--------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module qspi_top import qspi_cfg_pkg::*; (
  input  logic              clk,
  input  logic              rstn,
  // Host command stream
  input  logic              cmd_valid,
  input  logic [WORD_W-1:0] cmd_word,
  output logic              cmd_credit,
  // Host response stream
  output logic              rsp_valid,
  output logic [WORD_W-1:0] rsp_word,
  input  logic              rsp_credit,
  // SPI pins
  output logic              sck,
  output logic [CS_NUM-1:0] csn,
  output logic              mosi,
  output logic              mosi_en,
  input  logic              miso
);

  logic              word_valid;
  logic [WORD_W-1:0] word;
  logic              word_pop;

  qspi_shift_if shift_bus ();
  qspi_sck_if   sck_bus ();

  qspi_cmd_buffer u_buf (
    .clk        (clk),
    .rstn       (rstn),
    .cmd_valid  (cmd_valid),
    .cmd_word   (cmd_word),
    .cmd_credit (cmd_credit),
    .word_valid (word_valid),
    .word       (word),
    .word_pop   (word_pop)
  );

  qspi_sequencer u_seq (
    .clk        (clk),
    .rstn       (rstn),
    .word_valid (word_valid),
    .word       (word),
    .word_pop   (word_pop),
    .rsp_credit (rsp_credit),
    .rsp_valid  (rsp_valid),
    .rsp_word   (rsp_word),
    .csn        (csn),
    .shift      (shift_bus)
  );

  qspi_shifter u_shift (
    .clk     (clk),
    .rstn    (rstn),
    .shift   (shift_bus),
    .sck_bus (sck_bus),
    .mosi    (mosi),
    .mosi_en (mosi_en),
    .miso    (miso)
  );

  qspi_sck_gen u_sck (
    .clk     (clk),
    .rstn    (rstn),
    .sck     (sck),
    .sck_bus (sck_bus)
  );

endmodule

`default_nettype wire

/* sim/qspi_properties.sv */
//--------------------------------------------------------------------
// Flash controller protocol assertions
// Chip select exclusivity, mosi drive and response credit rules
//--------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module qspi_properties import qspi_cfg_pkg::*; (
  input  logic              clk,
  input  logic              rstn,
  input  logic [CS_NUM-1:0] csn,
  input  logic              mosi_en,
  input  logic              rsp_valid,
  input  logic              rsp_credit
);

  // Credits granted by the host and not yet used by a response
  logic [7:0] avail;
  int         fail_cnt = 0;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn)
      avail <= '0;
    else
      avail <= avail + {7'b0, rsp_credit} - {7'b0, rsp_valid};
  end

  // Never two devices selected at once
  a_one_cs: assert property (@(posedge clk) disable iff (!rstn)
    $countones(~csn) <= 1)
    else begin
      fail_cnt++;
      $error("more than one chip select is low");
    end

  // No response word without a granted slot
  a_rsp_credit: assert property (@(posedge clk) disable iff (!rstn)
    rsp_valid |-> (avail != 8'd0))
    else begin
      fail_cnt++;
      $error("rsp_valid without a response credit");
    end

  // mosi is released while no device is selected
  a_mosi_idle: assert property (@(posedge clk) disable iff (!rstn)
    (csn == '1) |-> !mosi_en)
    else begin
      fail_cnt++;
      $error("mosi_en high with all chip selects high");
    end

endmodule

`default_nettype wire

/* sim/qspi_tb.sv */
//--------------------------------------------------------------------
// Serial flash controller testbench
// Clock source, flash device model, case file stimulus and checks
//--------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

// 40 ns clock with reset held for the first 4 cycles
module tb_clock (
  output logic clk,
  output logic rstn
);
  localparam int HALF_PERIOD = 20;
  localparam int RST_CYCLES  = 4;

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  initial begin
    rstn = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    #2;
    rstn = 1'b1;
  end
endmodule

module qspi_tb import qspi_cfg_pkg::*, qspi_cmd_pkg::*; ();

  localparam int LIMIT       = 2000;
  localparam int HOLD_CYCLES = 30;
  // Wait conditions
  localparam int W_CMD_CREDIT   = 0;
  localparam int W_BITS         = 1;
  localparam int W_RSP          = 2;
  localparam int W_CS_HIGH      = 3;
  localparam int W_CREDITS_BACK = 4;

  logic              clk;
  logic              rstn;
  logic              cmd_valid;
  logic [WORD_W-1:0] cmd_word;
  logic              cmd_credit;
  logic              rsp_valid;
  logic [WORD_W-1:0] rsp_word;
  logic              rsp_credit;
  logic              sck;
  logic [CS_NUM-1:0] csn;
  logic              mosi;
  logic              mosi_en;
  logic              miso;

  // Bits captured by the flash model with the first bit at the MSB end
  logic [255:0]      cap_bits;
  logic [255:0]      cap_en;
  int                cap_n;
  logic [CS_NUM-1:0] cs_mask;
  int                rd_start;
  int                rd_bits;
  logic [WORD_W-1:0] rd_word;
  // Expected serial stream
  logic [255:0]      exp_bits;
  logic [255:0]      exp_en;
  int                exp_n;
  // Host side bookkeeping
  int                cmd_credits;
  int                cred_ret;
  int                rsp_cnt;
  logic [WORD_W-1:0] rsp_last;
  logic [7:0]        lfsr;
  int                errors;
  int                test_errs;
  int                tests;
  int                failed_tests;
  bit                aborted;

  tb_clock u_clk (
    .clk  (clk),
    .rstn (rstn)
  );

  qspi_top dut (
    .clk        (clk),
    .rstn       (rstn),
    .cmd_valid  (cmd_valid),
    .cmd_word   (cmd_word),
    .cmd_credit (cmd_credit),
    .rsp_valid  (rsp_valid),
    .rsp_word   (rsp_word),
    .rsp_credit (rsp_credit),
    .sck        (sck),
    .csn        (csn),
    .mosi       (mosi),
    .mosi_en    (mosi_en),
    .miso       (miso)
  );

  bind qspi_top qspi_properties u_props (
    .clk        (clk),
    .rstn       (rstn),
    .csn        (csn),
    .mosi_en    (mosi_en),
    .rsp_valid  (rsp_valid),
    .rsp_credit (rsp_credit)
  );

  //------------------------------------------------------------------
  // Flash device model
  //------------------------------------------------------------------
  // Mode 0 device samples mosi on the rising edge
  always @(posedge sck) begin
    if (csn != '1) begin
      cap_bits[255 - cap_n] = mosi;
      cap_en[255 - cap_n]   = mosi_en;
      cs_mask               = cs_mask | ~csn;
      cap_n                 = cap_n + 1;
    end
  end

  // Read bits change on the falling edge with each byte MSB first
  always @(negedge sck) begin
    int k;
    k = cap_n - rd_start;
    #2;
    if (k >= 0 && k < rd_bits)
      miso = rd_word[(k / 8) * 8 + 7 - (k % 8)];
    else
      miso = 1'b0;
  end

  // Returned command credits and response words seen mid-cycle
  always @(negedge clk) begin
    if (cmd_credit) begin
      cmd_credits = cmd_credits + 1;
      cred_ret    = cred_ret + 1;
    end
    if (rsp_valid) begin
      rsp_cnt  = rsp_cnt + 1;
      rsp_last = rsp_word;
    end
  end

  //------------------------------------------------------------------
  // Helpers
  //------------------------------------------------------------------
  // Fibonacci LFSR with taps x^8 + x^6 + x^5 + x^4 + 1
  function automatic logic [7:0] lfsr_next(input logic [7:0] s);
    return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
  endfunction

  task automatic rand_bits(input int n, output int v);
    v = 0;
    for (int i = 0; i < n; i++) begin
      v    = (v << 1) | int'(lfsr[7]);
      lfsr = lfsr_next(lfsr);
    end
  endtask

  task automatic check_word(input string name, input logic [WORD_W-1:0] got,
                            input logic [WORD_W-1:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
      test_errs++;
    end
  endtask

  task automatic check_hdr(input string name, input qspi_hdr_t got, input qspi_hdr_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
      test_errs++;
    end
  endtask

  task automatic check_csn(input string name, input logic [CS_NUM-1:0] got,
                           input logic [CS_NUM-1:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
      test_errs++;
    end
  endtask

  function automatic bit cond_met(input int what, input int target);
    case (what)
      W_CMD_CREDIT: return cmd_credits > 0;
      W_BITS:       return cap_n >= target;
      W_RSP:        return rsp_cnt >= target;
      W_CS_HIGH:    return csn == '1;
      default:      return cred_ret >= target;
    endcase
  endfunction

  // Polls once per cycle 2 ns after the edge
  task automatic wait_until(input int what, input int target, input string what_for,
                            output bit ok);
    int n;
    n  = 0;
    ok = 1'b1;
    while (!cond_met(what, target)) begin
      if (n == LIMIT) begin
        $display("Timeout while waiting for %s", what_for);
        ok = 1'b0;
        return;
      end
      @(posedge clk);
      #2;
      n++;
    end
  endtask

  task automatic push_word(input logic [WORD_W-1:0] w, output bit ok);
    wait_until(W_CMD_CREDIT, 0, "a command credit", ok);
    if (!ok)
      return;
    cmd_valid = 1'b1;
    cmd_word  = w;
    cmd_credits--;
    @(posedge clk);
    #2;
    cmd_valid = 1'b0;
  endtask

  task automatic grant_rsp_credit();
    rsp_credit = 1'b1;
    @(posedge clk);
    #2;
    rsp_credit = 1'b0;
  endtask

  task automatic add_byte(input logic [7:0] b, input logic en);
    for (int i = 7; i >= 0; i--) begin
      exp_bits[255 - exp_n] = b[i];
      exp_en[255 - exp_n]   = en;
      exp_n++;
    end
  endtask

  //------------------------------------------------------------------
  // One transaction from push to checks
  //------------------------------------------------------------------
  task automatic run_case(input qspi_hdr_t hdr, input logic [WORD_W-1:0] addr,
                          input logic [WORD_W-1:0] wdata, input logic [WORD_W-1:0] rdata,
                          input int hold, output bit ok);
    bit                has_addr;
    bit                writes;
    bit                reads;
    bit                dummy;
    bit                moved;
    int                na;
    int                nd;
    int                delay;
    int                nwords;
    logic [WORD_W-1:0] exp_rsp;
    qspi_hdr_t         obs;
    has_addr = hdr.seq inside {SEQ_CA, SEQ_CAR, SEQ_CADR, SEQ_CAW};
    writes   = hdr.seq inside {SEQ_CW, SEQ_CAW};
    reads    = hdr.seq inside {SEQ_CAR, SEQ_CADR, SEQ_CDR, SEQ_CR};
    dummy    = hdr.seq inside {SEQ_CADR, SEQ_CDR};
    na       = int'(hdr.addr_bytes) + 1;
    nd       = int'(hdr.data_bytes) + 1;
    // Opcode and address bytes with the high byte first
    exp_n    = 0;
    exp_bits = '0;
    exp_en   = '0;
    add_byte(hdr.opcode, 1'b1);
    if (has_addr)
      for (int b = na - 1; b >= 0; b--)
        add_byte(addr[8*b +: 8], 1'b1);
    if (dummy)
      for (int b = 0; b < int'(hdr.dummy_bytes); b++)
        add_byte(8'h00, 1'b0);
    rd_start = exp_n;
    // Write data goes out little endian with byte 0 first
    if (writes)
      for (int b = 0; b < nd; b++)
        add_byte(wdata[8*b +: 8], 1'b1);
    // Read phase leaves mosi released and upper unused bytes read as zero
    exp_rsp = '0;
    if (reads)
      for (int b = 0; b < nd; b++) begin
        add_byte(8'h00, 1'b0);
        exp_rsp[8*b +: 8] = rdata[8*b +: 8];
      end
    rd_word   = rdata;
    rd_bits   = reads ? 8 * nd : 0;
    cap_n     = 0;
    cap_bits  = '0;
    cap_en    = '0;
    cs_mask   = '0;
    cred_ret  = 0;
    rsp_cnt   = 0;
    nwords    = 1;
    test_errs = 0;
    moved     = 1'b0;

    push_word(hdr, ok);
    if (!ok)
      return;
    if (has_addr) begin
      push_word(addr, ok);
      if (!ok)
        return;
      nwords++;
    end
    if (writes) begin
      push_word(wdata, ok);
      if (!ok)
        return;
      nwords++;
    end

    if (reads) begin
      if (hold != 0) begin
        wait_until(W_BITS, rd_start, "the read phase", ok);
        if (!ok)
          return;
        // Without a credit the bus must park with the device selected
        for (int i = 0; i < HOLD_CYCLES; i++) begin
          @(posedge clk);
          #2;
          if (!moved && (csn == '1 || rsp_cnt != 0 || cap_n != rd_start)) begin
            $display("Read went ahead without a response credit after %0d cycles", i);
            test_errs++;
            moved = 1'b1;
          end
        end
      end
      rand_bits(4, delay);
      repeat (delay) begin
        @(posedge clk);
        #2;
      end
      grant_rsp_credit();
    end

    wait_until(W_BITS, exp_n, "the last serial bit", ok);
    if (!ok)
      return;
    if (reads) begin
      wait_until(W_RSP, 1, "rsp_valid", ok);
      if (!ok)
        return;
    end
    wait_until(W_CS_HIGH, 0, "the chip select release", ok);
    if (!ok)
      return;
    wait_until(W_CREDITS_BACK, nwords, "the command credits", ok);
    if (!ok)
      return;
    // Both lines stay high past the gap
    repeat (CMD_GAP + 2) begin
      @(posedge clk);
      #2;
    end

    obs        = hdr;
    obs.opcode = cap_bits[255 -: 8];
    obs.cs_sel = cs_mask[1];
    check_hdr("header", obs, hdr);
    check_csn("csn_low_mask", cs_mask, CS_NUM'(1) << hdr.cs_sel);
    check_csn("csn_between", csn, '1);
    check_word("bit_count", WORD_W'(cap_n), WORD_W'(exp_n));
    for (int k = 0; k * 32 < exp_n; k++) begin
      check_word($sformatf("mosi[%0d]", k), cap_bits[255 - 32*k -: 32],
                 exp_bits[255 - 32*k -: 32]);
      check_word($sformatf("mosi_en[%0d]", k), cap_en[255 - 32*k -: 32],
                 exp_en[255 - 32*k -: 32]);
    end
    check_word("cmd_credit_count", WORD_W'(cred_ret), WORD_W'(nwords));
    check_word("rsp_count", WORD_W'(rsp_cnt), WORD_W'(reads ? 1 : 0));
    if (reads)
      check_word("rsp_word", rsp_last, exp_rsp);
  endtask

  //------------------------------------------------------------------
  // Main sequence
  //------------------------------------------------------------------
  initial begin
    int                fd;
    int                got;
    int                hold;
    string             line;
    string             label;
    logic [WORD_W-1:0] h;
    logic [WORD_W-1:0] a;
    logic [WORD_W-1:0] w;
    logic [WORD_W-1:0] r;
    bit                ok;
    cmd_valid    = 1'b0;
    cmd_word     = '0;
    rsp_credit   = 1'b0;
    miso         = 1'b0;
    lfsr         = 8'd52;
    cmd_credits  = CMD_DEPTH;
    cap_n        = 0;
    rd_start     = 0;
    rd_bits      = 0;
    rd_word      = '0;
    errors       = 0;
    tests        = 0;
    failed_tests = 0;
    aborted      = 1'b0;

    repeat (6) @(posedge clk);
    #2;
    fd = $fopen("sim/qspi_cases.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the cases file sim/qspi_cases.txt");
      aborted = 1'b1;
    end
    while (!aborted && !$feof(fd)) begin
      if ($fgets(line, fd) == 0)
        break;
      // Skip comments and blank lines
      if (line.len() < 2 || line.getc(0) == "#")
        continue;
      got = $sscanf(line, "%h %h %h %h %d %s", h, a, w, r, hold, label);
      if (got != 6) begin
        $display("Malformed line in the cases file: %s", line);
        errors++;
        continue;
      end
      tests++;
      run_case(qspi_hdr_t'(h), a, w, r, hold, ok);
      if (!ok)
        aborted = 1'b1;
      errors += test_errs;
      if (test_errs != 0 || !ok)
        failed_tests++;
      $display("Test %0d %s: %s", tests, label, (test_errs == 0 && ok) ? "ok" : "FAILED");
    end
    if (fd != 0)
      $fclose(fd);

    $display("Tests run %0d, tests failed %0d, failed checks %0d, assertion failures %0d",
             tests, failed_tests, errors, dut.u_props.fail_cnt);
    if (errors == 0 && !aborted && tests > 0 && dut.u_props.fail_cnt == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
design/qspi_cfg_pkg.sv
design/qspi_cmd_pkg.sv
design/qspi_link_if.sv
design/qspi_cmd_buffer.sv
design/qspi_sequencer.sv
design/qspi_sck_gen.sv
design/qspi_shifter.sv
design/qspi_top.sv
sim/qspi_properties.sv
sim/qspi_tb.sv

/* Makefile */
# Verilator build and run of the serial flash controller testbench
# Any variable below can be overridden on the make command line

VERILATOR ?= verilator
TOP       ?= qspi_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Simulation passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The run passes only when the log holds the pass line
run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* sim/qspi_cases.txt */
# header   address  wr_data  rd_word  hold label
# hold 1 withholds the response credit until the read phase is reached
00000006 00000000 00000000 00000000 0 cmd_only_c
000C2303 00123456 00000000 A1B2C3D4 0 read_car_3addr
0004640B 00ABCDEF 00000000 55AA3C96 0 read_cadr_dummy1
00108A4B 00000000 00000000 123456E7 0 read_cdr_dummy2_cs1
000C3702 89ABCDEF DEADBEEF 00000000 0 write_caw_4addr
00140101 00000000 0000A55A 00000000 0 write_cw_cs1
00080303 00000077 00000000 00C0FFEE 1 read_backpressure
001C0C9F 00000000 00000000 00471FEF 0 read_cr_cs1
00001220 00004000 00000000 00000000 0 addr_only_ca
